// ==== l2_cache_stimulus.txt ====
# op id addr data hit, op R checks data as expected read data, op W writes data
# hit 1 must hit, 0 must miss, - not fixed by the replacement rule
# addr bits 31:10 tag, 9:5 set, 4:0 offset
R 1 00000400 0000040000000400000004000000040000000400000004000000040000000400 0
R 2 00000400 0000040000000400000004000000040000000400000004000000040000000400 1
W 3 00000400 cafe0001cafe0002cafe0003cafe0004cafe0005cafe0006cafe0007cafe0008 1
R 4 00000400 cafe0001cafe0002cafe0003cafe0004cafe0005cafe0006cafe0007cafe0008 1
W 5 00000820 beef0001beef0002beef0003beef0004beef0005beef0006beef0007beef0008 0
R 6 00000820 beef0001beef0002beef0003beef0004beef0005beef0006beef0007beef0008 1
W 7 00000440 d00d0001d00d0002d00d0003d00d0004d00d0005d00d0006d00d0007d00d0008 0
W 8 00000840 f00d0001f00d0002f00d0003f00d0004f00d0005f00d0006f00d0007f00d0008 0
W 9 00000c40 abcd0001abcd0002abcd0003abcd0004abcd0005abcd0006abcd0007abcd0008 0
W 10 00001040 1234000112340002123400031234000412340005123400061234000712340008 0
W 11 00001440 5678000156780002567800035678000456780005567800065678000756780008 0
R 12 00001440 5678000156780002567800035678000456780005567800065678000756780008 1
R 13 00000440 d00d0001d00d0002d00d0003d00d0004d00d0005d00d0006d00d0007d00d0008 0
R 14 00000840 f00d0001f00d0002f00d0003f00d0004f00d0005f00d0006f00d0007f00d0008 0
R 15 00000c40 abcd0001abcd0002abcd0003abcd0004abcd0005abcd0006abcd0007abcd0008 0
R 16 00001040 1234000112340002123400031234000412340005123400061234000712340008 0
R 17 00000460 0000046000000460000004600000046000000460000004600000046000000460 0
R 18 00000860 0000086000000860000008600000086000000860000008600000086000000860 0
R 19 00000c60 00000c6000000c6000000c6000000c6000000c6000000c6000000c6000000c60 0
R 20 00001060 0000106000001060000010600000106000001060000010600000106000001060 0
R 21 00001460 0000146000001460000014600000146000001460000014600000146000001460 0
R 22 00000460 0000046000000460000004600000046000000460000004600000046000000460 0
W 23 00000460 9abc00019abc00029abc00039abc00049abc00059abc00069abc00079abc0008 1
R 24 00000460 9abc00019abc00029abc00039abc00049abc00059abc00069abc00079abc0008 1
R 25 00000860 0000086000000860000008600000086000000860000008600000086000000860 0
W 26 00000820 a11a0001a11a0002a11a0003a11a0004a11a0005a11a0006a11a0007a11a0008 1
R 27 00000820 a11a0001a11a0002a11a0003a11a0004a11a0005a11a0006a11a0007a11a0008 1
R 28 00000c20 00000c2000000c2000000c2000000c2000000c2000000c2000000c2000000c20 0
R 29 00001020 0000102000001020000010200000102000001020000010200000102000001020 0
R 30 00001420 0000142000001420000014200000142000001420000014200000142000001420 0
R 31 00001820 0000182000001820000018200000182000001820000018200000182000001820 0
R 32 00000820 a11a0001a11a0002a11a0003a11a0004a11a0005a11a0006a11a0007a11a0008 0

// ==== l2_cache.f ====
l2_cache_pkg.sv
way_array.sv
plru_store.sv
l2_cache_datapath.sv
l2_cache_control.sv
l2_cache.sv
l2_cache_checker.sv
tb_l2_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the l2_cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_l2_cache \
    -f l2_cache.f -o tb_l2_cache

./obj_dir/tb_l2_cache > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== tb_l2_cache.sv ====
`timescale 1ns/1ns

module tb_l2_cache;
    import l2_cache_pkg::*;

    localparam int resp_timeout = 200;
    localparam int hit_latency  = 3;

    logic      clk;
    logic      rst_n;
    mem_req_t  mem_req;
    line_t     mem_rdata;
    logic      mem_resp;
    pmem_req_t pmem_req;
    line_t     pmem_rdata;
    logic      pmem_resp;

    // memory contents and reference model, keyed by line address
    line_t backing [logic [31:0]];
    line_t written [logic [31:0]];
    bit    dirty_lines [logic [31:0]];

    logic [31:0] lfsr;
    logic        mem_busy;
    int          mem_wait;
    line_t       mem_line;
    cache_addr_u cur_addr;
    int          reads_seen;
    int          writes_seen;
    int          errors;
    int          tests;
    bit          stuck;

    l2_cache dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_resp   (mem_resp),
        .pmem_req   (pmem_req),
        .pmem_rdata (pmem_rdata),
        .pmem_resp  (pmem_resp)
    );

    bind l2_cache l2_cache_checker protocol_checks (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp),
        .pmem_req  (pmem_req),
        .pmem_resp (pmem_resp)
    );

    always #4 clk = ~clk;

    // galois form, one step per random bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // unwritten memory line holds its own address in every word
    function automatic line_t fill_pattern(input logic [31:0] addr);
        return {8{addr}};
    endfunction

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input cache_addr_u got, input cache_addr_u exp);
        if (got.raw !== exp.raw) begin
            $display("ERR %s got %h exp %h", name, got.raw, exp.raw);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    // memory side, sampled mid cycle
    task automatic mem_sample();
        cache_addr_u line_addr;
        cache_addr_u exp_addr;
        logic        b0;
        logic        b1;
        if (!mem_busy && !pmem_resp && (pmem_req.read || pmem_req.write)) begin
            line_addr.raw = pmem_req.addr;
            b0 = lfsr[0];
            lfsr = lfsr_next(lfsr);
            b1 = lfsr[0];
            lfsr = lfsr_next(lfsr);
            mem_wait = 1 + int'({b1, b0});
            mem_busy = 1'b1;
            mem_line = '0;
            if (pmem_req.write) begin
                writes_seen++;
                if (dirty_lines.exists(line_addr.raw)) begin
                    check_line("pmem_req.wdata", pmem_req.wdata, written[line_addr.raw]);
                    dirty_lines.delete(line_addr.raw);
                end else begin
                    $display("write-back to line %h that holds no dirty data", line_addr.raw);
                    errors++;
                end
                backing[line_addr.raw] = pmem_req.wdata;
            end else begin
                reads_seen++;
                exp_addr = cur_addr;
                exp_addr.fields.offset = '0;
                check_addr("pmem_req.addr", line_addr, exp_addr);
                if (backing.exists(line_addr.raw)) begin
                    mem_line = backing[line_addr.raw];
                end else begin
                    mem_line = fill_pattern(line_addr.raw);
                end
            end
        end
    endtask

    // memory side, driven just after the rising edge
    task automatic mem_drive();
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        if (mem_busy) begin
            mem_wait--;
            if (mem_wait == 0) begin
                pmem_resp  = 1'b1;
                pmem_rdata = mem_line;
                mem_busy   = 1'b0;
            end
        end
    endtask

    task automatic run_request(input logic [7:0] op, input int id, input logic [31:0] addr,
                               input line_t data, input logic [7:0] hit_code);
        int          cycles;
        int          start_errors;
        int          start_reads;
        int          start_writes;
        bit          done;
        line_t       got_rdata;
        cache_addr_u line_addr;
        start_errors  = errors;
        start_reads   = reads_seen;
        start_writes  = writes_seen;
        cur_addr.raw  = addr;
        line_addr     = cur_addr;
        line_addr.fields.offset = '0;
        mem_req.read  = (op == "R");
        mem_req.write = (op == "W");
        mem_req.addr  = cur_addr;
        mem_req.wdata = (op == "W") ? data : '0;
        if (op == "W") begin
            written[line_addr.raw]     = data;
            dirty_lines[line_addr.raw] = 1'b1;
        end
        cycles    = 0;
        done      = 1'b0;
        got_rdata = '0;
        while (!done && cycles < resp_timeout) begin
            @(negedge clk);
            cycles++;
            mem_sample();
            if (mem_resp) begin
                done      = 1'b1;
                got_rdata = mem_rdata;
            end else begin
                @(posedge clk);
                #1;
                mem_drive();
            end
        end
        @(posedge clk);
        #1;
        mem_drive();
        mem_req = '0;
        if (!done) begin
            $display("test %0d: no mem_resp within %0d cycles", id, resp_timeout);
            errors++;
            stuck = 1'b1;
        end else begin
            if (op == "R") begin
                check_line("mem_rdata", got_rdata, data);
            end
            // first sampled cycle is the one before the request edge
            if (hit_code == "1") begin
                if (cycles - 1 != hit_latency) begin
                    $display("test %0d: hit answered after %0d cycles instead of %0d",
                             id, cycles - 1, hit_latency);
                    errors++;
                end
                check_flag("pmem_req.read", reads_seen != start_reads, 1'b0);
                check_flag("pmem_req.write", writes_seen != start_writes, 1'b0);
            end else if (hit_code == "0") begin
                check_flag("pmem_req.read", reads_seen != start_reads, 1'b1);
            end
        end
        tests++;
        if (errors == start_errors) begin
            $display("test %0d %c %h ok", id, op, addr);
        end else begin
            $display("test %0d %c %h mismatch", id, op, addr);
        end
    endtask

    initial begin
        int          fd;
        int          fields;
        string       text;
        logic [7:0]  op;
        int          id;
        logic [31:0] addr;
        line_t       data;
        logic [7:0]  hit_code;
        clk         = 1'b0;
        rst_n       = 1'b0;
        mem_req     = '0;
        pmem_rdata  = '0;
        pmem_resp   = 1'b0;
        lfsr        = 32'hdb887b45;
        mem_busy    = 1'b0;
        mem_wait    = 0;
        mem_line    = '0;
        cur_addr    = '0;
        reads_seen  = 0;
        writes_seen = 0;
        errors      = 0;
        tests       = 0;
        stuck       = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fd = $fopen("l2_cache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open l2_cache_stimulus.txt");
            errors++;
        end else begin
            while (!stuck && !$feof(fd)) begin
                if ($fgets(text, fd) != 0) begin
                    if (text.len() > 1 && text.getc(0) != "#") begin
                        fields = $sscanf(text, "%c %d %h %h %c", op, id, addr, data, hit_code);
                        if (fields == 5) begin
                            @(posedge clk);
                            #1;
                            run_request(op, id, addr, data, hit_code);
                        end else begin
                            $display("unreadable stimulus line: %s", text);
                            errors++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
        if (tests == 0) begin
            $display("no test was run");
            errors++;
        end
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== l2_cache_checker.sv ====
`timescale 1ns/1ns

module l2_cache_checker (
    input logic                    clk,
    input logic                    rst_n,
    input l2_cache_pkg::mem_req_t  mem_req,
    input logic                    mem_resp,
    input l2_cache_pkg::pmem_req_t pmem_req,
    input logic                    pmem_resp
);

    // only one memory strobe at a time while the client waits
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_req.read || mem_req.write) |-> !(pmem_req.read && pmem_req.write)
    ) else $error("pmem read and write strobes high together");

    resp_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_resp |=> !mem_resp
    ) else $error("mem_resp high for more than one cycle");

    // request held until memory answers
    pmem_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((pmem_req.read || pmem_req.write) && !pmem_resp) |=> $stable(pmem_req)
    ) else $error("pmem_req changed before pmem_resp");

    quiet_after_reset: assert property (
        @(posedge clk)
        !rst_n |=> (!mem_resp && !pmem_req.read && !pmem_req.write)
    ) else $error("response or memory strobe high in reset");

endmodule

// ==== l2_cache.sv ====
`timescale 1ns/1ns

module l2_cache (
    input  logic                    clk,
    input  logic                    rst_n,
    input  l2_cache_pkg::mem_req_t  mem_req,
    output l2_cache_pkg::line_t     mem_rdata,
    output logic                    mem_resp,
    output l2_cache_pkg::pmem_req_t pmem_req,
    input  l2_cache_pkg::line_t     pmem_rdata,
    input  logic                    pmem_resp
);
    import l2_cache_pkg::*;

    dp_ctrl_t    ctrl;
    dp_status_t  status;
    logic        pmem_read;
    logic        pmem_write;
    logic [31:0] pmem_addr;
    line_t       pmem_wdata;

    l2_cache_control control (
        .clk        (clk),
        .rst_n      (rst_n),
        .read       (mem_req.read),
        .write      (mem_req.write),
        .status     (status),
        .pmem_resp  (pmem_resp),
        .ctrl       (ctrl),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .mem_resp   (mem_resp)
    );

    l2_cache_datapath datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (mem_req),
        .ctrl       (ctrl),
        .pmem_rdata (pmem_rdata),
        .status     (status),
        .mem_rdata  (mem_rdata),
        .pmem_addr  (pmem_addr),
        .pmem_wdata (pmem_wdata)
    );

    // memory request gathered from both halves
    assign pmem_req.read  = pmem_read;
    assign pmem_req.write = pmem_write;
    assign pmem_req.addr  = pmem_addr;
    assign pmem_req.wdata = pmem_wdata;

endmodule

// ==== l2_cache_control.sv ====
`timescale 1ns/1ns

module l2_cache_control (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     read,
    input  logic                     write,
    input  l2_cache_pkg::dp_status_t status,
    input  logic                     pmem_resp,
    output l2_cache_pkg::dp_ctrl_t   ctrl,
    output logic                     pmem_read,
    output logic                     pmem_write,
    output logic                     mem_resp
);
    import l2_cache_pkg::*;

    cache_state_e state;
    cache_state_e next_state;

    // set for one cycle after the refill line has arrived
    logic refill_done;
    // remembers that the current request went down the miss path
    logic miss;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_idle;
            refill_done <= 1'b0;
            miss        <= 1'b0;
        end else begin
            state       <= next_state;
            refill_done <= (state == st_refill) && pmem_resp;
            if (state == st_compare) begin
                miss <= !status.hit;
            end else if (state == st_idle) begin
                miss <= 1'b0;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (read || write) begin
                    next_state = st_lookup;
                end
            end
            // arrays need a second cycle before the compare copy is ready
            st_lookup: begin
                next_state = st_compare;
            end
            st_compare: begin
                if (status.hit) begin
                    next_state = st_respond;
                end else if (status.victim_valid && status.victim_dirty) begin
                    next_state = st_writeback;
                end else begin
                    next_state = st_refill;
                end
            end
            st_writeback: begin
                if (pmem_resp) begin
                    next_state = st_refill;
                end
            end
            st_refill: begin
                if (refill_done) begin
                    next_state = st_respond;
                end
            end
            st_respond: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // memory strobes and client response straight from the state
    assign pmem_write = (state == st_writeback);
    assign pmem_read  = (state == st_refill) && !refill_done;
    assign mem_resp   = (state == st_respond);

    always_comb begin
        ctrl                  = '0;
        ctrl.valid_in         = 1'b1;
        // writes replace the whole line and leave it dirty
        ctrl.dirty_in         = write;
        ctrl.line_from_client = write;
        case (state)
            st_compare: begin
                if (status.hit) begin
                    ctrl.load_lru = 1'b1;
                    if (write) begin
                        ctrl.load_line  = 1'b1;
                        ctrl.load_dirty = 1'b1;
                    end
                end else begin
                    ctrl.way_sel_lru = 1'b1;
                    ctrl.load_wb_reg = 1'b1;
                end
            end
            st_writeback: begin
                ctrl.way_sel_lru      = 1'b1;
                ctrl.addr_from_victim = 1'b1;
            end
            st_refill: begin
                ctrl.way_sel_lru = 1'b1;
                if (refill_done) begin
                    // install line, tag and state bits in the victim way
                    ctrl.load_line       = 1'b1;
                    ctrl.load_valid      = 1'b1;
                    ctrl.load_dirty      = 1'b1;
                    ctrl.load_lru        = 1'b1;
                    ctrl.rdata_from_pmem = 1'b1;
                end
            end
            st_respond: begin
                ctrl.rdata_from_pmem = miss;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== l2_cache_datapath.sv ====
`timescale 1ns/1ns

module l2_cache_datapath (
    input  logic                     clk,
    input  logic                     rst_n,
    input  l2_cache_pkg::mem_req_t   req,
    input  l2_cache_pkg::dp_ctrl_t   ctrl,
    input  l2_cache_pkg::line_t      pmem_rdata,
    output l2_cache_pkg::dp_status_t status,
    output l2_cache_pkg::line_t      mem_rdata,
    output logic [31:0]              pmem_addr,
    output l2_cache_pkg::line_t      pmem_wdata
);
    import l2_cache_pkg::*;

    logic [tag_bits-1:0] req_tag;
    logic [set_bits-1:0] idx;

    line_t pmem_rdata_reg;
    line_t wb_line;
    line_t line_datain;

    // first copy comes out of the arrays, second copy feeds the compare
    line_t               data_out  [num_ways];
    line_t               data_reg  [num_ways];
    logic [tag_bits-1:0] tag_out   [num_ways];
    logic [tag_bits-1:0] tag_reg   [num_ways];
    logic                valid_out [num_ways];
    logic                valid_reg [num_ways];
    logic                dirty_out [num_ways];
    logic                dirty_reg [num_ways];

    logic [num_ways-1:0] load_data_way;
    logic [num_ways-1:0] load_valid_way;
    logic [num_ways-1:0] load_dirty_way;

    logic                hit;
    logic [way_bits-1:0] hit_way;
    logic [way_bits-1:0] victim_way;
    logic [way_bits-1:0] way_select;

    cache_addr_u wb_addr;
    cache_addr_u fill_addr;

    assign req_tag = req.addr.fields.tag;
    assign idx     = req.addr.fields.index;

    // memory line follows the bus until a fill starts consuming it
    always_ff @(posedge clk) begin
        if (!ctrl.rdata_from_pmem) begin
            pmem_rdata_reg <= pmem_rdata;
        end
    end

    assign line_datain = ctrl.line_from_client ? req.wdata : pmem_rdata_reg;

    generate
        for (genvar j = 0; j < num_ways; j++) begin : g_way
            way_array #(.width(line_bits)) data_array (
                .clk     (clk),
                .rst_n   (rst_n),
                .write   (load_data_way[j]),
                .index   (idx),
                .datain  (line_datain),
                .dataout (data_out[j])
            );

            way_array #(.width(tag_bits)) tag_array (
                .clk     (clk),
                .rst_n   (rst_n),
                .write   (load_data_way[j]),
                .index   (idx),
                .datain  (req_tag),
                .dataout (tag_out[j])
            );

            way_array #(.width(1)) valid_array (
                .clk     (clk),
                .rst_n   (rst_n),
                .write   (load_valid_way[j]),
                .index   (idx),
                .datain  (ctrl.valid_in),
                .dataout (valid_out[j])
            );

            way_array #(.width(1)) dirty_array (
                .clk     (clk),
                .rst_n   (rst_n),
                .write   (load_dirty_way[j]),
                .index   (idx),
                .datain  (ctrl.dirty_in),
                .dataout (dirty_out[j])
            );
        end
    endgenerate

    always_ff @(posedge clk) begin
        for (int i = 0; i < num_ways; i++) begin
            data_reg[i] <= data_out[i];
            tag_reg[i]  <= tag_out[i];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < num_ways; i++) begin
            if (!rst_n) begin
                valid_reg[i] <= 1'b0;
                dirty_reg[i] <= 1'b0;
            end else begin
                valid_reg[i] <= valid_out[i];
                dirty_reg[i] <= dirty_out[i];
            end
        end
    end

    plru_store plru (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (idx),
        .update     (ctrl.load_lru),
        .access_way (way_select),
        .victim_way (victim_way)
    );

    // tag compare across all ways
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (valid_reg[i] && tag_reg[i] == req_tag) begin
                hit     = 1'b1;
                hit_way = i[way_bits-1:0];
            end
        end
    end

    assign way_select = ctrl.way_sel_lru ? victim_way : hit_way;

    always_comb begin
        for (int i = 0; i < num_ways; i++) begin
            load_data_way[i]  = ctrl.load_line && (way_select == i[way_bits-1:0]);
            load_valid_way[i] = ctrl.load_valid && (way_select == i[way_bits-1:0]);
            load_dirty_way[i] = ctrl.load_dirty && (way_select == i[way_bits-1:0]);
        end
    end

    assign status.hit          = hit;
    assign status.victim_valid = valid_reg[victim_way];
    assign status.victim_dirty = dirty_reg[victim_way];

    // victim line held for the whole write-back
    always_ff @(posedge clk) begin
        if (ctrl.load_wb_reg) begin
            wb_line <= data_reg[victim_way];
        end
    end

    always_comb begin
        wb_addr.fields.tag    = tag_reg[victim_way];
        wb_addr.fields.index  = idx;
        wb_addr.fields.offset = '0;
        fill_addr               = req.addr;
        fill_addr.fields.offset = '0;
    end

    assign pmem_addr  = ctrl.addr_from_victim ? wb_addr.raw : fill_addr.raw;
    assign pmem_wdata = wb_line;
    assign mem_rdata  = ctrl.rdata_from_pmem ? pmem_rdata_reg : data_reg[hit_way];

endmodule

// ==== plru_store.sv ====
`timescale 1ns/1ns

module plru_store (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [l2_cache_pkg::set_bits-1:0] index,
    input  logic                              update,
    input  logic [l2_cache_pkg::way_bits-1:0] access_way,
    output logic [l2_cache_pkg::way_bits-1:0] victim_way
);
    import l2_cache_pkg::*;

    // node 0 is the root, node 1 covers ways 0 and 1, node 2 covers ways 2 and 3
    // a node value of 1 points the victim to its upper half
    logic [num_ways-2:0] tree [num_sets];
    logic [num_ways-2:0] cur_tree;

    assign cur_tree = tree[index];

    // follow the pointers down from the root
    assign victim_way = {cur_tree[0], cur_tree[0] ? cur_tree[2] : cur_tree[1]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                tree[s] <= '0;
            end
        end else if (update) begin
            // point every node on the accessed path away from it
            tree[index][0] <= ~access_way[1];
            if (access_way[1]) begin
                tree[index][2] <= ~access_way[0];
            end else begin
                tree[index][1] <= ~access_way[0];
            end
        end
    end

endmodule

// ==== way_array.sv ====
`timescale 1ns/1ns

module way_array #(
    parameter int width = 1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            write,
    input  logic [l2_cache_pkg::set_bits-1:0] index,
    input  logic [width-1:0]                datain,
    output logic [width-1:0]                dataout
);
    import l2_cache_pkg::*;

    logic [width-1:0] entries [num_sets];

    // one entry per set, read out through a register every cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_sets; i++) begin
                entries[i] <= '0;
            end
            dataout <= '0;
        end else begin
            if (write) begin
                entries[index] <= datain;
                // written value shows up on the output next cycle
                dataout <= datain;
            end else begin
                dataout <= entries[index];
            end
        end
    end

endmodule

// ==== l2_cache_pkg.sv ====
package l2_cache_pkg;

    // cache geometry
    localparam int set_bits    = 5;
    localparam int way_bits    = 2;
    localparam int offset_bits = 5;
    localparam int tag_bits    = 32 - offset_bits - set_bits;
    localparam int num_sets    = 1 << set_bits;
    localparam int num_ways    = 1 << way_bits;
    localparam int line_bits   = 256;

    typedef logic [line_bits-1:0] line_t;

    // byte address split into tag, set index and line offset
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [set_bits-1:0]    index;
        logic [offset_bits-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t fields;
    } cache_addr_u;

    // client side request, held until mem_resp
    typedef struct packed {
        logic        read;
        logic        write;
        cache_addr_u addr;
        line_t       wdata;
    } mem_req_t;

    // memory side request, held until pmem_resp
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        line_t       wdata;
    } pmem_req_t;

    typedef struct packed {
        logic way_sel_lru;
        logic load_line;
        logic load_valid;
        logic load_dirty;
        logic load_lru;
        logic line_from_client;
        logic valid_in;
        logic dirty_in;
        logic addr_from_victim;
        logic rdata_from_pmem;
        logic load_wb_reg;
    } dp_ctrl_t;

    typedef struct packed {
        logic hit;
        logic victim_valid;
        logic victim_dirty;
    } dp_status_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_compare,
        st_writeback,
        st_refill,
        st_respond
    } cache_state_e;

endpackage
